//--- verilog/mixPkg.sv
/*
 MIX shared definitions: word and field types, the opcodes of the
 reduced instruction set, write-data selects and the control states.
*/
package mixPkg;

	// sign in bit 30, bytes 1..5 from bit 29 down to bit 0
	typedef logic [30:0] mixWord;
	typedef logic [29:0] mixMagnitude;
	typedef logic [5:0] mixByte;
	typedef logic [11:0] mixAddress;
	// L in bits 5:3, R in bits 2:0
	typedef logic [5:0] mixField;
	typedef logic [5:0] mixOpcode;
	typedef logic [2:0] mixSelect;

	localparam int memoryDepth = 4096;

	localparam mixOpcode opNop = 6'd0;
	localparam mixOpcode opAdd = 6'd1;
	localparam mixOpcode opSub = 6'd2;
	localparam mixOpcode opSpecial = 6'd5;
	localparam mixOpcode opLda = 6'd8;
	localparam mixOpcode opLd1 = 6'd9;
	localparam mixOpcode opLdx = 6'd15;
	localparam mixOpcode opSta = 6'd24;
	localparam mixOpcode opSt1 = 6'd25;
	localparam mixOpcode opStx = 6'd31;
	localparam mixOpcode opJmp = 6'd39;
	localparam mixOpcode opEntA = 6'd48;
	localparam mixOpcode opEnt1 = 6'd49;
	localparam mixOpcode opCmpA = 6'd56;
	localparam mixOpcode opCmpX = 6'd63;

	// register and memory write data sources
	localparam mixSelect selField = 3'd0;
	localparam mixSelect selSum = 3'd1;
	localparam mixSelect selIncrement = 3'd2;
	localparam mixSelect selAddress = 3'd3;
	localparam mixSelect selMerged = 3'd4;

	typedef enum logic [2:0] {
		stIdle,
		stFetch,
		stDecode,
		stExecute,
		stHalted
	} mixState;

endpackage

//--- verilog/mixMemory.sv
/*
 MIX main memory. 4096 words of synchronous RAM with one port for the
 core and one for the host; the core wins a write to the same address.
*/
`timescale 1ns/10ps
module mixMemory (
	input logic clk,
	input mixPkg::mixAddress coreAddress,
	input logic coreWrite,
	input mixPkg::mixWord coreWriteData,
	output mixPkg::mixWord coreReadData,
	input mixPkg::mixAddress hostAddress,
	input logic hostWrite,
	input mixPkg::mixWord hostWriteData,
	output mixPkg::mixWord hostReadData
);
	import mixPkg::*;

	mixWord memory [memoryDepth];

	always_ff @(posedge clk) begin
		if (hostWrite && !(coreWrite && coreAddress == hostAddress))
			memory[hostAddress] <= hostWriteData;
		if (coreWrite)
			memory[coreAddress] <= coreWriteData;
		// both ports read the old word
		coreReadData <= memory[coreAddress];
		hostReadData <= memory[hostAddress];
	end

endmodule

//--- verilog/mixAddressUnit.sv
/*
 MIX address unit. Adds I1 to the signed AA field of an instruction in
 sign-magnitude form and keeps the low 12 bits as the memory address.
*/
`timescale 1ns/10ps
module mixAddressUnit (
	input mixPkg::mixWord instruction,
	input logic indexSpec,
	input mixPkg::mixWord indexOne,
	output mixPkg::mixAddress effectiveAddress
);
	import mixPkg::*;

	mixAddress addressPart;
	mixAddress indexPart;
	logic [12:0] magnitude;

	assign addressPart = instruction[29:18];
	// I1 only contributes when the I byte selects it
	assign indexPart = indexSpec ? indexOne[11:0] : '0;

	always_comb begin
		if (instruction[30] == indexOne[30])
			magnitude = {1'b0, addressPart} + {1'b0, indexPart};
		else if (addressPart >= indexPart)
			magnitude = {1'b0, addressPart} - {1'b0, indexPart};
		else
			magnitude = {1'b0, indexPart} - {1'b0, addressPart};
	end

	// sign of M is dropped, carry out of bit 11 wraps
	assign effectiveAddress = magnitude[11:0];

endmodule

//--- verilog/mixFieldUnit.sv
/*
 MIX field unit. Extracts the partial field (L:R) of a word right-aligned,
 and merges the low bytes of a register into positions L..R of a word.
*/
`timescale 1ns/10ps
module mixFieldUnit (
	input mixPkg::mixWord word,
	input mixPkg::mixField field,
	input mixPkg::mixWord source,
	output mixPkg::mixWord fieldValue,
	output mixPkg::mixWord mergedWord
);
	import mixPkg::*;

	int lowPos;
	int highPos;

	assign lowPos = int'(field[5:3]);
	assign highPos = int'(field[2:0]);

	always_comb begin
		int first;
		mixByte sourceByte;
		first = (lowPos == 0) ? 1 : lowPos;
		fieldValue = '0;
		mergedWord = word;
		sourceByte = '0;
		// sign takes part only when L is zero
		if (lowPos == 0) begin
			fieldValue[30] = word[30];
			mergedWord[30] = source[30];
		end
		// byte p sits at bits (5-p)*6 and moves to (R-p)*6 when right-aligned
		for (int p = 1; p <= 5; p++) begin
			if (p >= first && p <= highPos && highPos <= 5) begin
				fieldValue[(highPos - p) * 6 +: 6] = word[(5 - p) * 6 +: 6];
				sourceByte = source[(highPos - p) * 6 +: 6];
				mergedWord[(5 - p) * 6 +: 6] = sourceByte;
			end
		end
	end

endmodule

//--- verilog/mixArithmetic.sv
/*
 MIX arithmetic unit. Sign-magnitude add and subtract with overflow
 beyond 30 bits, and a signed three-way compare where +0 equals -0.
*/
`timescale 1ns/10ps
module mixArithmetic (
	input mixPkg::mixWord left,
	input mixPkg::mixWord right,
	input logic subtract,
	output mixPkg::mixWord sum,
	output logic overflow,
	output logic less,
	output logic equal,
	output logic greater
);
	import mixPkg::*;

	mixMagnitude leftMagnitude;
	mixMagnitude rightMagnitude;
	logic rightSign;
	logic sumSign;
	logic [30:0] magnitude;
	logic signed [31:0] leftValue;
	logic signed [31:0] rightValue;

	assign leftMagnitude = left[29:0];
	assign rightMagnitude = right[29:0];
	// subtraction flips the sign of the right operand
	assign rightSign = right[30] ^ subtract;

	always_comb begin
		sumSign = left[30];
		if (left[30] == rightSign) begin
			magnitude = {1'b0, leftMagnitude} + {1'b0, rightMagnitude};
		end else if (leftMagnitude >= rightMagnitude) begin
			// an exact cancel stays with the sign of left
			magnitude = {1'b0, leftMagnitude} - {1'b0, rightMagnitude};
		end else begin
			magnitude = {1'b0, rightMagnitude} - {1'b0, leftMagnitude};
			sumSign = rightSign;
		end
	end

	assign sum = {sumSign, magnitude[29:0]};
	assign overflow = magnitude[30];

	// both zeros map to the same signed value
	assign leftValue = left[30] ? -$signed({2'b00, leftMagnitude})
		: $signed({2'b00, leftMagnitude});
	assign rightValue = right[30] ? -$signed({2'b00, rightMagnitude})
		: $signed({2'b00, rightMagnitude});

	assign less = leftValue < rightValue;
	assign equal = leftValue == rightValue;
	assign greater = leftValue > rightValue;

endmodule

//--- verilog/mixRegisters.sv
/*
 MIX register file. Holds A, X, I1 and J; I1 keeps a sign and twelve
 magnitude bits and reads back as a full word.
*/
`timescale 1ns/10ps
module mixRegisters (
	input logic clk,
	input logic reset,
	input logic writeA,
	input logic writeX,
	input logic writeOne,
	input logic writeJ,
	input mixPkg::mixWord writeValue,
	input mixPkg::mixAddress jumpReturn,
	output mixPkg::mixWord registerA,
	output mixPkg::mixWord registerX,
	output mixPkg::mixWord indexOne,
	output mixPkg::mixAddress registerJ
);
	import mixPkg::*;

	logic indexSign;
	mixAddress indexMagnitude;

	always_ff @(posedge clk) begin
		if (reset) begin
			registerA <= '0;
			registerX <= '0;
			indexSign <= 1'b0;
			indexMagnitude <= '0;
			registerJ <= '0;
		end else begin
			if (writeA)
				registerA <= writeValue;
			if (writeX)
				registerX <= writeValue;
			// bytes 1..3 of the value are dropped for I1
			if (writeOne) begin
				indexSign <= writeValue[30];
				indexMagnitude <= writeValue[11:0];
			end
			if (writeJ)
				registerJ <= jumpReturn;
		end
	end

	assign indexOne = {indexSign, 18'd0, indexMagnitude};

endmodule

//--- verilog/mixControl.sv
/*
 MIX control unit. Steps fetch, decode and execute, keeps the program
 counter and the overflow and comparison flags, and decodes each
 instruction into register writes, stores, jumps and halt.
*/
`timescale 1ns/10ps
module mixControl (
	input logic clk,
	input logic reset,
	input logic start,
	input mixPkg::mixAddress startAddress,
	input mixPkg::mixWord instruction,
	input mixPkg::mixAddress effectiveAddress,
	input logic overflowIn,
	input logic less,
	input logic equal,
	input logic greater,
	output mixPkg::mixAddress memAddress,
	output logic memWrite,
	output logic writeA,
	output logic writeX,
	output logic writeOne,
	output logic writeJ,
	output mixPkg::mixSelect writeSelect,
	output logic subtract,
	output logic compareX,
	output logic operandOne,
	output mixPkg::mixField field,
	output mixPkg::mixAddress programCounter,
	output logic running,
	output logic halted
);
	import mixPkg::*;

	mixState state;
	mixWord currentWord;
	mixAddress operandAddress;
	mixOpcode opcode;
	logic overflowFlag;
	logic lessFlag;
	logic equalFlag;
	logic greaterFlag;
	logic jumpTaken;
	logic halt;
	logic setsOverflow;

	assign opcode = currentWord[5:0];
	assign field = currentWord[11:6];

	// fetch reads at P, decode reads at the new M, execute keeps M
	always_comb begin
		case (state)
			stDecode: memAddress = effectiveAddress;
			stExecute: memAddress = operandAddress;
			default: memAddress = programCounter;
		endcase
	end

	always_comb begin
		case (field)
			6'd0, 6'd1: jumpTaken = 1'b1;
			6'd2: jumpTaken = overflowFlag;
			6'd3: jumpTaken = !overflowFlag;
			6'd4: jumpTaken = lessFlag;
			6'd5: jumpTaken = equalFlag;
			6'd6: jumpTaken = greaterFlag;
			default: jumpTaken = 1'b0;
		endcase
	end

	// decode is only active during execute
	always_comb begin
		memWrite = 1'b0;
		writeA = 1'b0;
		writeX = 1'b0;
		writeOne = 1'b0;
		writeJ = 1'b0;
		writeSelect = selField;
		subtract = 1'b0;
		compareX = 1'b0;
		operandOne = 1'b0;
		halt = 1'b0;
		if (state == stExecute) begin
			case (opcode)
				opNop, opCmpA: ;
				opAdd, opSub: begin
					writeA = 1'b1;
					writeSelect = selSum;
					subtract = (opcode == opSub);
				end
				opSpecial: halt = (field == 6'd2);
				opLda: writeA = 1'b1;
				opLd1: writeOne = 1'b1;
				opLdx: writeX = 1'b1;
				opSta, opSt1, opStx: begin
					memWrite = 1'b1;
					writeSelect = selMerged;
					operandOne = (opcode == opSt1);
					compareX = (opcode == opStx);
				end
				// JSJ leaves J alone
				opJmp: writeJ = jumpTaken && field != 6'd1;
				opEntA, opEnt1: begin
					// F 0 is INC, 1 is DEC, 2 is ENT
					if (field <= 6'd2) begin
						writeA = (opcode == opEntA);
						writeOne = (opcode == opEnt1);
						operandOne = (opcode == opEnt1);
						writeSelect = (field == 6'd2) ? selAddress : selIncrement;
						subtract = (field == 6'd1);
					end
				end
				opCmpX: compareX = 1'b1;
				default: ;
			endcase
		end
	end

	// only A arithmetic touches the overflow toggle
	assign setsOverflow = writeA && (writeSelect == selSum || writeSelect == selIncrement);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
			programCounter <= '0;
			running <= 1'b0;
			halted <= 1'b0;
			overflowFlag <= 1'b0;
			lessFlag <= 1'b0;
			equalFlag <= 1'b1;
			greaterFlag <= 1'b0;
		end else begin
			case (state)
				stIdle, stHalted: begin
					if (start) begin
						state <= stFetch;
						programCounter <= startAddress;
						running <= 1'b1;
						halted <= 1'b0;
					end
				end
				stFetch: begin
					programCounter <= programCounter + mixAddress'(1);
					state <= stDecode;
				end
				stDecode: state <= stExecute;
				stExecute: begin
					if (halt) begin
						state <= stHalted;
						running <= 1'b0;
						halted <= 1'b1;
					end else begin
						state <= stFetch;
					end
					if (opcode == opJmp && jumpTaken)
						programCounter <= operandAddress;
					// JOV and JNOV both clear the toggle
					if (opcode == opJmp && (field == 6'd2 || field == 6'd3))
						overflowFlag <= 1'b0;
					else if (setsOverflow && overflowIn)
						overflowFlag <= 1'b1;
					if (opcode == opCmpA || opcode == opCmpX) begin
						lessFlag <= less;
						equalFlag <= equal;
						greaterFlag <= greater;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// instruction word and M held through execute
	always_ff @(posedge clk) begin
		if (state == stDecode) begin
			currentWord <= instruction;
			operandAddress <= effectiveAddress;
		end
	end

endmodule

//--- verilog/mixCore.sv
/*
 MIX core top level. Connects control, address, field and arithmetic
 units, the register file and memory, with a host port for loading.
*/
`timescale 1ns/10ps
module mixCore (
	input logic clk,
	input logic reset,
	input logic start,
	input mixPkg::mixAddress startAddress,
	input mixPkg::mixAddress hostAddress,
	input logic hostWrite,
	input mixPkg::mixWord hostWriteData,
	output mixPkg::mixWord hostReadData,
	output logic running,
	output logic halted
);
	import mixPkg::*;

	mixWord readData;
	mixWord writeValue;
	mixWord fieldValue;
	mixWord mergedWord;
	mixWord sum;
	mixWord registerA;
	mixWord registerX;
	mixWord indexOne;
	mixWord operandRegister;
	mixWord rightOperand;
	mixWord addressWord;
	mixAddress memAddress;
	mixAddress effectiveAddress;
	mixAddress programCounter;
	mixField field;
	mixSelect writeSelect;
	logic memWrite;
	logic writeA;
	logic writeX;
	logic writeOne;
	logic writeJ;
	logic subtract;
	logic compareX;
	logic operandOne;
	logic overflow;
	logic less;
	logic equal;
	logic greater;

	// M as a positive word, valid in execute
	assign addressWord = {1'b0, 18'd0, memAddress};
	assign operandRegister = compareX ? registerX : (operandOne ? indexOne : registerA);
	assign rightOperand = (writeSelect == selIncrement) ? addressWord : fieldValue;

	always_comb begin
		case (writeSelect)
			selSum, selIncrement: writeValue = sum;
			selAddress: writeValue = addressWord;
			selMerged: writeValue = mergedWord;
			default: writeValue = fieldValue;
		endcase
	end

	mixControl control (
		.clk(clk), .reset(reset), .start(start), .startAddress(startAddress),
		.instruction(readData), .effectiveAddress(effectiveAddress),
		.overflowIn(overflow), .less(less), .equal(equal), .greater(greater),
		.memAddress(memAddress), .memWrite(memWrite),
		.writeA(writeA), .writeX(writeX), .writeOne(writeOne), .writeJ(writeJ),
		.writeSelect(writeSelect), .subtract(subtract), .compareX(compareX),
		.operandOne(operandOne), .field(field), .programCounter(programCounter),
		.running(running), .halted(halted)
	);

	// host writes are locked out while a program runs
	mixMemory memory (
		.clk(clk), .coreAddress(memAddress), .coreWrite(memWrite),
		.coreWriteData(writeValue), .coreReadData(readData),
		.hostAddress(hostAddress), .hostWrite(hostWrite && !running),
		.hostWriteData(hostWriteData), .hostReadData(hostReadData)
	);

	// readData holds the instruction during decode, when M is formed
	mixAddressUnit addressUnit (
		.instruction(readData), .indexSpec(readData[17:12] == 6'd1),
		.indexOne(indexOne), .effectiveAddress(effectiveAddress)
	);

	mixFieldUnit fieldUnit (
		.word(readData), .field(field), .source(operandRegister),
		.fieldValue(fieldValue), .mergedWord(mergedWord)
	);

	mixArithmetic arithmetic (
		.left(operandRegister), .right(rightOperand), .subtract(subtract),
		.sum(sum), .overflow(overflow), .less(less), .equal(equal), .greater(greater)
	);

	// J has no reader in this core
	mixRegisters registers (
		.clk(clk), .reset(reset), .writeA(writeA), .writeX(writeX),
		.writeOne(writeOne), .writeJ(writeJ), .writeValue(writeValue),
		.jumpReturn(programCounter), .registerA(registerA), .registerX(registerX),
		.indexOne(indexOne), .registerJ()
	);

endmodule

//--- testbench/mixCore_checker.sv
/*
 MIX control checker. Concurrent assertions on the run control and
 the memory write strobe of the control unit.
*/
`timescale 1ns/10ps
module mixCore_checker (
	input logic clk,
	input logic reset,
	input logic start,
	input mixPkg::mixState state,
	input logic memWrite,
	input logic running,
	input logic halted
);
	import mixPkg::*;

	// stores only happen in the execute step
	writeInExecute: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> state == stExecute)
		else $error("memory write outside execute");

	runOrHalt: assert property (@(posedge clk) disable iff (reset)
		!(running && halted))
		else $error("running and halted both high");

	// only a new start clears halted
	haltHolds: assert property (@(posedge clk) disable iff (reset)
		halted && !start |=> halted)
		else $error("halted dropped without start");

endmodule

//--- testbench/mixCore_tb.sv
/*
 MIX core testbench. Loads small programs over the host port, runs
 them and compares the word at address 100 with a reference model.
*/
`timescale 1ns/10ps
module mixCore_tb;
	import mixPkg::*;

	localparam int numTests = 17;
	localparam int kindLoad = 0;
	localparam int kindArith = 1;
	localparam int kindMerge = 2;
	localparam int kindCompare = 3;
	localparam int kindIndex = 4;
	localparam int kindLock = 5;
	// longest executed path and host traffic per test, in cycles
	localparam int maxExecuted = 8;
	localparam int loadCycles = 48;
	localparam longint timeoutNs = longint'(numTests) * (3 * maxExecuted + loadCycles) * 20 * 4;
	localparam mixWord markerLess = 31'h0000_0111;
	localparam mixWord markerEqual = 31'h0000_0222;
	localparam mixWord markerGreater = 31'h0000_0333;

	logic clk;
	logic reset;
	logic start;
	mixAddress startAddress;
	mixAddress hostAddress;
	logic hostWrite;
	mixWord hostWriteData;
	mixWord hostReadData;
	logic running;
	logic halted;

	string testName [numTests];
	int testKind [numTests];
	mixOpcode testOp [numTests];
	mixField testField [numTests];
	mixWord dataOne [numTests];
	mixWord dataTwo [numTests];
	mixWord expected [numTests];
	mixWord code [$];
	logic [31:0] randomState;
	int tableSize;
	int errorCount;
	int passCount;
	int failCount;

	mixCore u_dut (
		.clk(clk), .reset(reset), .start(start), .startAddress(startAddress),
		.hostAddress(hostAddress), .hostWrite(hostWrite), .hostWriteData(hostWriteData),
		.hostReadData(hostReadData), .running(running), .halted(halted)
	);

	bind mixControl mixCore_checker controlChecker (
		.clk(clk), .reset(reset), .start(start), .state(state),
		.memWrite(memWrite), .running(running), .halted(halted)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic mixWord randomWord();
		randomState = xorshift(randomState);
		return randomState[30:0];
	endfunction

	// sign, AA, I, F, C
	function automatic mixWord encode(input mixOpcode op, input int aa, input int index,
		input int f);
		mixWord w;
		w = '0;
		w[29:18] = aa[11:0];
		w[17:12] = index[5:0];
		w[11:6] = f[5:0];
		w[5:0] = op;
		return w;
	endfunction

	function automatic longint wordValue(input mixWord w);
		longint magnitude;
		magnitude = longint'(w[29:0]);
		return w[30] ? -magnitude : magnitude;
	endfunction

	function automatic mixWord fieldModel(input mixWord w, input mixField f);
		int lo;
		int hi;
		longint value;
		mixWord r;
		lo = int'(f[5:3]);
		hi = int'(f[2:0]);
		value = 0;
		for (int p = (lo == 0) ? 1 : lo; p <= hi; p++)
			value = value * 64 + longint'(w[29 - 6 * (p - 1) -: 6]);
		r = {1'b0, value[29:0]};
		if (lo == 0)
			r[30] = w[30];
		return r;
	endfunction

	function automatic mixWord mergeModel(input mixWord w, input mixField f, input mixWord src);
		int lo;
		int hi;
		mixWord r;
		mixMagnitude remaining;
		lo = int'(f[5:3]);
		hi = int'(f[2:0]);
		r = w;
		remaining = src[29:0];
		// rightmost source bytes fill from position R leftwards
		for (int p = hi; p >= ((lo == 0) ? 1 : lo) && p >= 1; p--) begin
			r[29 - 6 * (p - 1) -: 6] = remaining[5:0];
			remaining = remaining >> 6;
		end
		if (lo == 0)
			r[30] = src[30];
		return r;
	endfunction

	function automatic mixWord addModel(input mixWord a, input mixWord b, input logic sub,
		output logic overflow);
		longint total;
		longint magnitude;
		mixWord r;
		total = wordValue(a) + (sub ? -wordValue(b) : wordValue(b));
		magnitude = (total < 0) ? -total : total;
		overflow = magnitude >= (longint'(1) << 30);
		r[29:0] = magnitude[29:0];
		if (total < 0)
			r[30] = 1'b1;
		else if (total > 0)
			r[30] = 1'b0;
		else
			r[30] = a[30];
		return r;
	endfunction

	function automatic mixWord expectedFor(input int i);
		logic overflow;
		logic taken;
		mixWord sum;
		longint difference;
		case (testKind[i])
			kindLoad: return fieldModel(dataOne[i], testField[i]);
			kindArith: begin
				sum = addModel(dataOne[i], dataTwo[i], testOp[i] == opSub, overflow);
				taken = (testField[i] == 6'd2) ? overflow : !overflow;
				return taken ? markerLess : sum;
			end
			kindMerge: return mergeModel(dataTwo[i], testField[i], dataOne[i]);
			kindCompare: begin
				difference = wordValue(dataOne[i]) - wordValue(dataTwo[i]);
				if (difference < 0)
					return markerLess;
				return (difference == 0) ? markerEqual : markerGreater;
			end
			kindIndex: return addModel({1'b0, 18'd0, dataTwo[i][11:0]}, dataOne[i], 1'b0,
				overflow);
			default: return dataOne[i];
		endcase
	endfunction

	task automatic addTest(input string name, input int kind, input mixOpcode op,
		input mixField f, input mixWord one, input mixWord two);
		testName[tableSize] = name;
		testKind[tableSize] = kind;
		testOp[tableSize] = op;
		testField[tableSize] = f;
		dataOne[tableSize] = one;
		dataTwo[tableSize] = two;
		expected[tableSize] = expectedFor(tableSize);
		tableSize++;
	endtask

	task automatic setupTable();
		mixWord r1;
		mixWord r2;
		r1 = randomWord();
		r2 = randomWord();
		addTest("lda 0:5", kindLoad, opLda, 6'd5, r1, r2);
		addTest("lda 1:5", kindLoad, opLda, 6'd13, randomWord(), r2);
		addTest("ldx 3:3", kindLoad, opLdx, 6'd27, randomWord(), r2);
		addTest("ldx 0:2", kindLoad, opLdx, 6'd2, randomWord() | 31'h4000_0000, r2);
		addTest("add jov", kindArith, opAdd, 6'd2, randomWord(), randomWord());
		r1 = randomWord();
		r2 = randomWord();
		// top magnitude bits set on both sides force a carry out
		addTest("add jov overflow", kindArith, opAdd, 6'd2, {1'b0, 2'b11, r1[27:0]},
			{1'b0, 2'b11, r2[27:0]});
		addTest("sub jnov", kindArith, opSub, 6'd3, randomWord(), randomWord());
		addTest("sub jnov overflow", kindArith, opSub, 6'd3, {1'b1, 2'b11, r2[27:0]},
			{1'b0, 2'b11, r1[27:0]});
		addTest("sta 0:3 merge", kindMerge, opSta, 6'd3, randomWord() | 31'h4000_0000,
			randomWord());
		addTest("sta 2:4 merge", kindMerge, opSta, 6'd20, randomWord() | 31'h4000_0000,
			randomWord());
		addTest("sta 5:5 merge", kindMerge, opSta, 6'd45, randomWord(), randomWord());
		addTest("cmpa random", kindCompare, opCmpA, 6'd5, randomWord(), randomWord());
		addTest("cmpx random", kindCompare, opCmpX, 6'd5, randomWord(), randomWord());
		addTest("cmpa zeros", kindCompare, opCmpA, 6'd5, 31'h0000_0000, 31'h4000_0000);
		r1 = randomWord();
		addTest("cmpx equal", kindCompare, opCmpX, 6'd5, r1, r1);
		addTest("indexed add", kindIndex, opAdd, 6'd5, randomWord(), randomWord());
		addTest("host write lock", kindLock, opNop, 6'd0, randomWord(), randomWord());
	endtask

	task automatic buildProgram(input int i);
		code.delete();
		case (testKind[i])
			kindLoad: begin
				code.push_back(encode(testOp[i], 200, 0, int'(testField[i])));
				code.push_back(encode((testOp[i] == opLda) ? opSta : opStx, 100, 0, 5));
			end
			kindArith: begin
				code.push_back(encode(opLda, 200, 0, 5));
				code.push_back(encode(testOp[i], 201, 0, 5));
				code.push_back(encode(opJmp, 5, 0, int'(testField[i])));
				code.push_back(encode(opSta, 100, 0, 5));
				code.push_back(encode(opSpecial, 0, 0, 2));
				code.push_back(encode(opLda, 300, 0, 5));
				code.push_back(encode(opSta, 100, 0, 5));
			end
			kindMerge: begin
				code.push_back(encode(opLda, 200, 0, 5));
				code.push_back(encode(opSta, 100, 0, int'(testField[i])));
			end
			kindCompare: begin
				code.push_back(encode((testOp[i] == opCmpA) ? opLda : opLdx, 200, 0, 5));
				code.push_back(encode(testOp[i], 201, 0, 5));
				code.push_back(encode(opJmp, 5, 0, 4));
				code.push_back(encode(opJmp, 8, 0, 5));
				code.push_back(encode(opJmp, 11, 0, 6));
				for (int m = 0; m < 3; m++) begin
					code.push_back(encode(opLda, 300 + m, 0, 5));
					code.push_back(encode(opSta, 100, 0, 5));
					if (m < 2)
						code.push_back(encode(opSpecial, 0, 0, 2));
				end
			end
			kindIndex: begin
				// I1 = 3 + 6, so the indexed operand sits at 209
				code.push_back(encode(opEnt1, 3, 0, 2));
				code.push_back(encode(opEnt1, 6, 0, 0));
				code.push_back(encode(opEntA, int'(dataTwo[i][11:0]), 0, 2));
				code.push_back(encode(opAdd, 200, 1, 5));
				code.push_back(encode(opSta, 100, 0, 5));
			end
			default: begin
				code.push_back(encode(opNop, 0, 0, 0));
				code.push_back(encode(opNop, 0, 0, 0));
				code.push_back(encode(opNop, 0, 0, 0));
			end
		endcase
		code.push_back(encode(opSpecial, 0, 0, 2));
	endtask

	task automatic writeWord(input int address, input mixWord value);
		@(posedge clk);
		hostAddress <= mixAddress'(address);
		hostWrite <= 1'b1;
		hostWriteData <= value;
	endtask

	task automatic stopWrite();
		@(posedge clk);
		hostWrite <= 1'b0;
	endtask

	task automatic readWord(input int address, output mixWord value);
		@(posedge clk);
		hostAddress <= mixAddress'(address);
		hostWrite <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		value = hostReadData;
	endtask

	task automatic runTest(input int i);
		mixWord actual;
		int errorsBefore;
		errorsBefore = errorCount;
		buildProgram(i);
		foreach (code[k])
			writeWord(k, code[k]);
		// unindexed address holds another word in the index test
		writeWord(200, (testKind[i] == kindIndex) ? ~dataOne[i] : dataOne[i]);
		writeWord(201, dataTwo[i]);
		writeWord(209, dataOne[i]);
		writeWord(300, markerLess);
		writeWord(301, markerEqual);
		writeWord(302, markerGreater);
		// word at 100 starts different from the stored result
		if (testKind[i] == kindMerge)
			writeWord(100, dataTwo[i]);
		else if (testKind[i] == kindLock)
			writeWord(100, dataOne[i]);
		else
			writeWord(100, ~expected[i]);
		stopWrite();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (testKind[i] == kindLock) begin
			@(negedge clk);
			assert (running) else begin
				$display("%s: core was not running when the host write was tried",
					testName[i]);
				errorCount++;
			end
			writeWord(100, dataTwo[i]);
			stopWrite();
		end
		@(negedge clk);
		while (!halted)
			@(negedge clk);
		assert (!running) else begin
			$display("%s: running still high after the core halted", testName[i]);
			errorCount++;
		end
		readWord(100, actual);
		assert (actual == expected[i]) else begin
			$display("[ERROR] %s expected %h actual %h", testName[i], expected[i], actual);
			errorCount++;
		end
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %s: ok", testName[i]);
		end else begin
			failCount++;
			$display("test %s: failed", testName[i]);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		startAddress = '0;
		hostAddress = '0;
		hostWrite = 1'b0;
		hostWriteData = '0;
		randomState = 32'hc42b_945b;
		tableSize = 0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		setupTable();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < tableSize; i++)
			runTest(i);
		$display("%0d tests: %0d passed, %0d failed, %0d errors", tableSize, passCount,
			failCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// a program that never halts ends here
	initial begin
		#(timeoutNs);
		$display("watchdog expired: a program did not reach halt in time");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- compile.f
verilog/mixPkg.sv
verilog/mixMemory.sv
verilog/mixAddressUnit.sv
verilog/mixFieldUnit.sv
verilog/mixArithmetic.sv
verilog/mixRegisters.sv
verilog/mixControl.sv
verilog/mixCore.sv
testbench/mixCore_checker.sv
testbench/mixCore_tb.sv

//--- Makefile
# Verilator build and run of the MIX core testbench

VERILATOR ?= verilator
TOP ?= mixCore_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
